//--- hbus_defines.svh
/*
 * HyperBus controller parameters
 * Host address and burst length widths, initial access latency
 */
`ifndef HBUS_DEFINES_SVH
`define HBUS_DEFINES_SVH

// Host word address width
`define HBUS_ADDR_W 22

// Burst length field, holds words minus one
`define HBUS_LEN_W 4

// Initial latency in clock cycles for memory accesses
`define HBUS_LATENCY 6

`endif

//--- hbus_cmd_pkg.sv
/*
 * Host command types for the HyperBus controller
 * Opcodes, data words, addresses and burst lengths
 */
`include "hbus_defines.svh"

package hbus_cmd_pkg;

  // Host opcodes
  typedef enum logic [1:0] {
    HBUS_MEM_RD = 2'b00,
    HBUS_MEM_WR = 2'b01,
    HBUS_REG_RD = 2'b10,
    HBUS_REG_WR = 2'b11
  } hbus_op_e;

  // One burst data word
  typedef logic [15:0] hbus_word_t;

  typedef logic [`HBUS_ADDR_W-1:0] hbus_addr_t;

  // Number of words minus one
  typedef logic [`HBUS_LEN_W-1:0] hbus_len_t;

endpackage

//--- hbus_bus_pkg.sv
/*
 * HyperBus side types
 * Controller states and the 48-bit command-address word
 */
package hbus_bus_pkg;

  typedef enum logic [2:0] {
    IDLE    = 3'd0,
    CA      = 3'd1,
    LATENCY = 3'd2,
    WRITE   = 3'd3,
    READ    = 3'd4,
    DONE    = 3'd5
  } hbus_state_e;

  // Sent most significant byte first
  typedef struct packed {
    logic        rw;         // 1 for read
    logic        reg_space;  // 1 for register space
    logic        linear;     // linear burst
    logic [28:0] addr_hi;
    logic [12:0] rsvd;
    logic [2:0]  addr_lo;
  } hbus_ca_t;

endpackage

//--- hbus_seq_if.sv
/*
 * Sequencing controls from the control FSM to the CA shifter and data path
 */
interface hbus_seq_if;

  logic ca_load;
  logic ca_shift;
  logic wr_phase;
  logic rd_phase;
  // High byte selected when set
  logic byte_sel;
  logic word_done;

  modport ctrl (
    output ca_load, ca_shift, wr_phase, rd_phase, byte_sel,
    input  word_done
  );

  modport ca (
    input ca_load, ca_shift
  );

  modport dp (
    input  wr_phase, rd_phase, byte_sel,
    output word_done
  );

endinterface

//--- hbus_ctrl_fsm.sv
/*
 * HyperBus control FSM
 * Sequences chip select, command-address, latency and data phases
 */
`include "hbus_defines.svh"

module hbus_ctrl_fsm
  import hbus_cmd_pkg::*;
  import hbus_bus_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      req_i,
  input  hbus_op_e  op_i,
  input  hbus_len_t len_i,
  output logic      busy_o,
  output logic      done_o,
  output logic      wdata_req_o,
  output logic      cs_n_o,
  output logic      ck_en_o,
  hbus_seq_if.ctrl  seq
);

  localparam int unsigned CA_BYTES = 6;
  localparam int unsigned CNT_MAX  = (`HBUS_LATENCY > CA_BYTES) ? `HBUS_LATENCY : CA_BYTES;
  localparam int unsigned CNT_W    = $clog2(CNT_MAX);

  hbus_state_e      state_q, state_d;
  hbus_op_e         op_q;
  hbus_len_t        rem_q;
  logic [CNT_W-1:0] cnt_q;
  logic             cs_n_q;
  logic             byte_sel_q;
  logic             done_q;
  logic             accept;
  logic             is_wr;
  logic             ca_last;
  logic             lat_last;
  logic             last_word;

  assign accept    = req_i && (state_q == IDLE);
  assign is_wr     = (op_q == HBUS_MEM_WR) || (op_q == HBUS_REG_WR);
  assign ca_last   = (state_q == CA) && (cnt_q == CNT_W'(CA_BYTES - 1));
  assign lat_last  = (state_q == LATENCY) && (cnt_q == CNT_W'(`HBUS_LATENCY - 1));
  assign last_word = seq.word_done && (rem_q == '0);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: if (req_i) state_d = CA;
      CA: begin
        // Register writes carry no latency
        if (ca_last) state_d = (op_q == HBUS_REG_WR) ? WRITE : LATENCY;
      end
      LATENCY: if (lat_last) state_d = is_wr ? WRITE : READ;
      WRITE, READ: if (last_word) state_d = DONE;
      DONE: state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= IDLE;
      op_q       <= HBUS_MEM_RD;
      rem_q      <= '0;
      cnt_q      <= '0;
      cs_n_q     <= 1'b1;
      byte_sel_q <= 1'b1;
      done_q     <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= (state_q == DONE);
      // High byte first in every word
      byte_sel_q <= (state_q == WRITE) ? ~byte_sel_q : 1'b1;
      cs_n_q     <= (state_d == IDLE) || (state_d == DONE);
      if (accept) begin
        op_q  <= op_i;
        rem_q <= len_i;
      end else if (seq.word_done && (rem_q != '0)) begin
        rem_q <= rem_q - 1'b1;
      end
      if (state_d != state_q) begin
        cnt_q <= '0;
      end else if ((state_q == CA) || (state_q == LATENCY)) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // Word request one cycle ahead of its high byte
  assign wdata_req_o = (ca_last && (op_q == HBUS_REG_WR))
                    || (lat_last && (op_q == HBUS_MEM_WR))
                    || ((state_q == WRITE) && !byte_sel_q && (rem_q != '0));

  assign busy_o  = (state_q != IDLE);
  assign done_o  = done_q;
  assign cs_n_o  = cs_n_q;
  assign ck_en_o = ~cs_n_q;

  assign seq.ca_load  = accept;
  assign seq.ca_shift = (state_q == CA);
  assign seq.wr_phase = (state_q == WRITE);
  assign seq.rd_phase = (state_q == READ);
  assign seq.byte_sel = byte_sel_q;

  a_cs_fall_from_idle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $fell(cs_n_o) |-> (state_q == CA) && $past(req_i))
    else $error("chip select fell without an accepted request");

  // A stray word done would count down the remaining words
  a_word_done_in_phase: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    seq.word_done |-> (seq.wr_phase || seq.rd_phase))
    else $error("word done outside a data phase");

endmodule

//--- hbus_ca_shifter.sv
/*
 * Command-address shifter
 * Packs the 48-bit CA word and sends it one byte per cycle, MSB first
 */
`include "hbus_defines.svh"

module hbus_ca_shifter
  import hbus_cmd_pkg::*;
  import hbus_bus_pkg::*;
(
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  hbus_op_e   op_i,
  input  hbus_addr_t addr_i,
  hbus_seq_if.ca     seq,
  output logic [7:0] ca_byte_o,
  output logic       ca_oe_o
);

  hbus_ca_t   ca_d;
  logic [47:0] ca_q;
  logic [2:0]  shift_cnt_q;

  always_comb begin
    ca_d.rw        = (op_i == HBUS_MEM_RD) || (op_i == HBUS_REG_RD);
    ca_d.reg_space = (op_i == HBUS_REG_RD) || (op_i == HBUS_REG_WR);
    ca_d.linear    = 1'b1;
    ca_d.addr_hi   = 29'(addr_i[`HBUS_ADDR_W-1:3]);
    ca_d.rsvd      = '0;
    ca_d.addr_lo   = addr_i[2:0];
  end

  always_ff @(posedge clk_i) begin
    if (seq.ca_load) begin
      ca_q <= ca_d;
    end else if (seq.ca_shift) begin
      ca_q <= {ca_q[39:0], 8'h00};
    end
  end

  // Bytes sent since the last load
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      shift_cnt_q <= '0;
    end else if (seq.ca_load) begin
      shift_cnt_q <= '0;
    end else if (seq.ca_shift) begin
      shift_cnt_q <= shift_cnt_q + 1'b1;
    end
  end

  assign ca_byte_o = ca_q[47:40];
  assign ca_oe_o   = seq.ca_shift;

  a_six_shifts: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    seq.ca_shift |-> (shift_cnt_q < 3'd6))
    else $error("more than 6 CA bytes after one load");

endmodule

//--- hbus_data_path.sv
/*
 * HyperBus data path
 * Drives CA and write bytes on DQ with RWDS masking, assembles read words
 */
module hbus_data_path
  import hbus_cmd_pkg::*;
(
  input  logic       clk_i,
  input  logic       arst_n_i,
  hbus_seq_if.dp     seq,
  input  hbus_word_t wdata_i,
  input  logic [1:0] wstrb_i,
  input  logic [7:0] ca_byte_i,
  input  logic       ca_oe_i,
  output logic [7:0] dq_o,
  output logic       dq_oe_o,
  input  logic [7:0] dq_i,
  output logic       rwds_o,
  output logic       rwds_oe_o,
  input  logic       rwds_i,
  output hbus_word_t rdata_o,
  output logic       rdata_valid_o
);

  logic [7:0] wr_lo_q;
  logic       wr_lo_strb_q;
  logic [7:0] rd_hi_q;
  logic       rd_wait_hi_q;
  hbus_word_t rdata_q;
  logic       rvalid_q;
  logic       rd_take;

  // Low byte held so the host may change wdata_i after the high byte
  always_ff @(posedge clk_i) begin
    if (seq.wr_phase && seq.byte_sel) begin
      wr_lo_q      <= wdata_i[7:0];
      wr_lo_strb_q <= wstrb_i[0];
    end
  end

  always_comb begin
    if (ca_oe_i) begin
      dq_o = ca_byte_i;
    end else if (seq.byte_sel) begin
      dq_o = wdata_i[15:8];
    end else begin
      dq_o = wr_lo_q;
    end
  end

  assign dq_oe_o   = ca_oe_i || seq.wr_phase;
  // RWDS high masks the byte
  assign rwds_o    = seq.byte_sel ? ~wstrb_i[1] : ~wr_lo_strb_q;
  assign rwds_oe_o = seq.wr_phase;

  // Device strobes each valid read byte with RWDS
  assign rd_take = seq.rd_phase && rwds_i;

  always_ff @(posedge clk_i) begin
    if (rd_take && rd_wait_hi_q) begin
      rd_hi_q <= dq_i;
    end
    if (rd_take && !rd_wait_hi_q) begin
      rdata_q <= {rd_hi_q, dq_i};
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_wait_hi_q <= 1'b1;
      rvalid_q     <= 1'b0;
    end else begin
      rvalid_q <= rd_take && !rd_wait_hi_q;
      if (!seq.rd_phase) begin
        rd_wait_hi_q <= 1'b1;
      end else if (rd_take) begin
        rd_wait_hi_q <= ~rd_wait_hi_q;
      end
    end
  end

  assign seq.word_done = (seq.wr_phase && !seq.byte_sel) || (rd_take && !rd_wait_hi_q);

  assign rdata_o       = rdata_q;
  assign rdata_valid_o = rvalid_q;

  a_no_dq_drive_in_read: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    seq.rd_phase |-> !dq_oe_o)
    else $error("DQ driven during read phase");

endmodule

//--- hbus_top.sv
/*
 * HyperBus memory controller top level
 * Runs host commands as single-chip-select HyperBus transactions
 */
module hbus_top
  import hbus_cmd_pkg::*;
(
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  logic       req_i,
  input  hbus_op_e   op_i,
  input  hbus_addr_t addr_i,
  input  hbus_len_t  len_i,
  input  hbus_word_t wdata_i,
  input  logic [1:0] wstrb_i,
  output logic       wdata_req_o,
  output hbus_word_t rdata_o,
  output logic       rdata_valid_o,
  output logic       busy_o,
  output logic       done_o,
  output logic       hyper_cs_n_o,
  output logic       hyper_ck_en_o,
  output logic       hyper_reset_n_o,
  output logic [7:0] hyper_dq_o,
  output logic       hyper_dq_oe_o,
  input  logic [7:0] hyper_dq_i,
  output logic       hyper_rwds_o,
  output logic       hyper_rwds_oe_o,
  input  logic       hyper_rwds_i
);

  logic [7:0] ca_byte;
  logic       ca_oe;

  hbus_seq_if seq_if ();

  hbus_ctrl_fsm i_ctrl_fsm (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_i       (req_i),
    .op_i        (op_i),
    .len_i       (len_i),
    .busy_o      (busy_o),
    .done_o      (done_o),
    .wdata_req_o (wdata_req_o),
    .cs_n_o      (hyper_cs_n_o),
    .ck_en_o     (hyper_ck_en_o),
    .seq         (seq_if.ctrl)
  );

  hbus_ca_shifter i_ca_shifter (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .op_i      (op_i),
    .addr_i    (addr_i),
    .seq       (seq_if.ca),
    .ca_byte_o (ca_byte),
    .ca_oe_o   (ca_oe)
  );

  hbus_data_path i_data_path (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .seq           (seq_if.dp),
    .wdata_i       (wdata_i),
    .wstrb_i       (wstrb_i),
    .ca_byte_i     (ca_byte),
    .ca_oe_i       (ca_oe),
    .dq_o          (hyper_dq_o),
    .dq_oe_o       (hyper_dq_oe_o),
    .dq_i          (hyper_dq_i),
    .rwds_o        (hyper_rwds_o),
    .rwds_oe_o     (hyper_rwds_oe_o),
    .rwds_i        (hyper_rwds_i),
    .rdata_o       (rdata_o),
    .rdata_valid_o (rdata_valid_o)
  );

  // Device reset follows the controller reset
  assign hyper_reset_n_o = arst_n_i;

endmodule

//--- tb_hbus_model.sv
/*
 * Behavioral HyperRAM for the controller testbench
 * 256-word memory and a configuration register, SDR bytes, fixed latency
 */
`include "hbus_defines.svh"

module tb_hbus_model
  import hbus_cmd_pkg::*;
  import hbus_bus_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       cs_n_i,
  input  logic [7:0] dq_i,
  input  logic       rwds_i,
  output logic [7:0] dq_o,
  output logic       rwds_o
);

  hbus_word_t  mem [256];
  hbus_word_t  cfg_reg;
  hbus_word_t  word;
  logic [47:0] ca_bits;
  hbus_ca_t    ca;
  logic [7:0]  base;
  int          cyc;
  int          lat;
  int          byte_idx;
  int          rd_word;
  int          slot;
  int          idle_pos;

  // cyc is the index of the bus cycle that ends at this edge
  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < 256; i++) begin
        mem[i] = 16'hffff;
      end
      cfg_reg = 16'h8f1f;
      cyc     = 0;
      dq_o   <= 8'h00;
      rwds_o <= 1'b0;
    end else if (cs_n_i) begin
      cyc     = 0;
      dq_o   <= 8'h00;
      rwds_o <= 1'b0;
    end else begin
      // Six CA bytes, most significant first
      if (cyc < 6) begin
        ca_bits = {ca_bits[39:0], dq_i};
      end
      if (cyc == 5) begin
        ca       = hbus_ca_t'(ca_bits);
        base     = {ca.addr_hi[4:0], ca.addr_lo};
        lat      = (ca.reg_space && !ca.rw) ? 0 : `HBUS_LATENCY;
        rd_word  = 0;
        slot     = 0;
        idle_pos = int'($urandom_range(1, 0));
      end
      // Write bytes, high byte first, RWDS high keeps the stored byte
      if (!ca.rw && cyc >= 6 + lat && !rwds_i) begin
        byte_idx = cyc - 6 - lat;
        word = ca.reg_space ? cfg_reg : mem[base + 8'(byte_idx / 2)];
        if (byte_idx % 2 == 0) begin
          word[15:8] = dq_i;
        end else begin
          word[7:0] = dq_i;
        end
        if (ca.reg_space) begin
          cfg_reg = word;
        end else begin
          mem[base + 8'(byte_idx / 2)] = word;
        end
      end
      // Three slots per read word, one of them idle with RWDS low
      if (ca.rw && cyc >= 5 + lat) begin
        word = ca.reg_space ? cfg_reg : mem[base + 8'(rd_word)];
        if (slot == idle_pos) begin
          rwds_o <= 1'b0;
        end else begin
          rwds_o <= 1'b1;
          dq_o   <= (slot == 2) ? word[7:0] : word[15:8];
        end
        slot = slot + 1;
        if (slot == 3) begin
          slot     = 0;
          rd_word  = rd_word + 1;
          idle_pos = int'($urandom_range(1, 0));
        end
      end
      cyc = cyc + 1;
    end
  end

endmodule

//--- tb_hbus.sv
/*
 * Testbench for the HyperBus memory controller
 * Applies a table of register and memory transactions against a HyperRAM model
 */
`include "hbus_defines.svh"

module tb_hbus
  import hbus_cmd_pkg::*;
();

  localparam int ROWS = 7;
  localparam logic [1:0] K_FIXED = 2'd0;
  localparam logic [1:0] K_MASK  = 2'd1;
  localparam logic [1:0] K_RAND  = 2'd2;

  typedef struct packed {
    hbus_op_e   op;
    hbus_addr_t addr;
    hbus_len_t  len;
    logic [1:0] kind;
    hbus_word_t word;
  } row_t;

  logic       clk_i, arst_n_i, req_i;
  hbus_op_e   op_i;
  hbus_addr_t addr_i;
  hbus_len_t  len_i;
  hbus_word_t wdata_i, rdata_o;
  logic [1:0] wstrb_i;
  logic       wdata_req_o, rdata_valid_o, busy_o, done_o;
  logic       hyper_cs_n_o, hyper_ck_en_o, hyper_reset_n_o;
  logic [7:0] hyper_dq_o, hyper_dq_i;
  logic       hyper_dq_oe_o, hyper_rwds_o, hyper_rwds_oe_o, hyper_rwds_i;

  row_t       rows [ROWS];
  hbus_word_t wr_tab [ROWS][16];
  logic [1:0] st_tab [ROWS][16];
  hbus_word_t exp_tab [ROWS][16];
  hbus_word_t rnd [16];
  int         cycles = 0;
  int         limit;

  hbus_top i_dut (.*);

  tb_hbus_model i_mem (
    .clk_i   (clk_i),
    .rst_n_i (hyper_reset_n_o),
    .cs_n_i  (hyper_cs_n_o),
    .dq_i    (hyper_dq_o),
    .rwds_i  (hyper_rwds_o),
    .dq_o    (hyper_dq_i),
    .rwds_o  (hyper_rwds_i)
  );

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles > limit) begin
      $display("Timeout: the run did not finish within %0d clock cycles", limit);
      $display("Test failed");
      $fatal(1, "timeout");
    end
  end

  task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("error at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
      $display("Test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // Expected words keep the erased byte wherever the strobe is clear
  task automatic fill_table();
    logic [1:0] st;
    hbus_word_t w;
    rows[0] = '{HBUS_REG_RD, 22'd0, 4'd0, K_FIXED, 16'h8f1f};
    rows[1] = '{HBUS_REG_WR, 22'd0, 4'd0, K_FIXED, 16'h8f17};
    rows[2] = '{HBUS_REG_RD, 22'd0, 4'd0, K_FIXED, 16'h8f17};
    rows[3] = '{HBUS_MEM_WR, 22'd16, 4'd15, K_MASK, 16'h3456};
    rows[4] = '{HBUS_MEM_RD, 22'd16, 4'd15, K_MASK, 16'h3456};
    rows[5] = '{HBUS_MEM_WR, 22'd64, 4'd7, K_RAND, 16'h0000};
    rows[6] = '{HBUS_MEM_RD, 22'd64, 4'd7, K_RAND, 16'h0000};
    for (int i = 0; i < 16; i++) begin
      rnd[i] = 16'($urandom);
    end
    limit = 30;
    for (int r = 0; r < ROWS; r++) begin
      limit += 10 + `HBUS_LATENCY + 3 * (int'(rows[r].len) + 1);
      for (int i = 0; i < 16; i++) begin
        w  = (rows[r].kind == K_RAND) ? rnd[i] : rows[r].word;
        st = (rows[r].kind == K_MASK) ? 2'(i % 4) : 2'b11;
        wr_tab[r][i]  = w;
        st_tab[r][i]  = st;
        exp_tab[r][i] = {st[1] ? w[15:8] : 8'hff, st[0] ? w[7:0] : 8'hff};
      end
    end
  endtask

  task automatic run_row(input int r);
    int   n_req;
    int   n_valid;
    int   n_dq_oe;
    int   n_rwds_oe;
    int   cs_low;
    int   lat;
    int   words;
    logic is_wr;
    logic cs_prev;
    logic cs_prev2;
    n_req     = 0;
    n_valid   = 0;
    n_dq_oe   = 0;
    n_rwds_oe = 0;
    cs_low    = 0;
    cs_prev   = 1'b1;
    cs_prev2  = 1'b1;
    is_wr     = (rows[r].op == HBUS_MEM_WR) || (rows[r].op == HBUS_REG_WR);
    lat       = (rows[r].op == HBUS_REG_WR) ? 0 : `HBUS_LATENCY;
    words     = int'(rows[r].len) + 1;
    @(negedge clk_i);
    compare("chip select idle before request", 32'(hyper_cs_n_o), 1);
    compare("busy before request", 32'(busy_o), 0);
    compare("done pulse longer than one cycle", 32'(done_o), 0);
    req_i  = 1'b1;
    op_i   = rows[r].op;
    addr_i = rows[r].addr;
    len_i  = rows[r].len;
    @(negedge clk_i);
    req_i = 1'b0;
    while (!done_o) begin
      if (!hyper_cs_n_o) begin
        cs_low++;
      end
      // Device clock runs only while selected
      compare("clock enable", 32'(hyper_ck_en_o), 32'(!hyper_cs_n_o));
      if (hyper_dq_oe_o) begin
        n_dq_oe++;
      end
      if (hyper_rwds_oe_o) begin
        n_rwds_oe++;
      end
      if (wdata_req_o) begin
        wdata_i = wr_tab[r][n_req % 16];
        wstrb_i = st_tab[r][n_req % 16];
        n_req++;
      end
      if (rdata_valid_o) begin
        compare("read word", 32'(rdata_o), 32'(exp_tab[r][n_valid % 16]));
        n_valid++;
      end
      cs_prev2 = cs_prev;
      cs_prev  = hyper_cs_n_o;
      @(negedge clk_i);
    end
    // Done comes one cycle after chip select rises
    compare("chip select before done", 32'({cs_prev2, cs_prev}), 32'b01);
    compare("write data requests", n_req, is_wr ? words : 0);
    compare("read words", n_valid, is_wr ? 0 : words);
    compare("DQ drive cycles", n_dq_oe, 6 + (is_wr ? 2 * words : 0));
    compare("RWDS drive cycles", n_rwds_oe, is_wr ? 2 * words : 0);
    if (is_wr) begin
      compare("chip select low cycles", cs_low, 6 + lat + 2 * words);
    end
  endtask

  initial begin
    clk_i    = 1'b0;
    arst_n_i = 1'b0;
    req_i    = 1'b0;
    op_i     = HBUS_MEM_RD;
    addr_i   = '0;
    len_i    = '0;
    wdata_i  = '0;
    wstrb_i  = '0;
    void'($urandom(32'h10c25f8f));
    fill_table();
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    compare("chip select in reset", 32'(hyper_cs_n_o), 1);
    compare("clock enable in reset", 32'(hyper_ck_en_o), 0);
    compare("output enables in reset", 32'({hyper_dq_oe_o, hyper_rwds_oe_o}), 0);
    compare("host strobes in reset",
            32'({busy_o, done_o, wdata_req_o, rdata_valid_o}), 0);
    compare("device reset", 32'(hyper_reset_n_o), 0);
    arst_n_i = 1'b1;
    for (int r = 0; r < ROWS; r++) begin
      run_row(r);
    end
    @(negedge clk_i);
    compare("idle at end", 32'({hyper_cs_n_o, busy_o, done_o, hyper_reset_n_o}), 32'b1001);
    $display("Test completed successfully");
    $finish;
  end

endmodule

//--- flist.f
+incdir+.
hbus_cmd_pkg.sv
hbus_bus_pkg.sv
hbus_seq_if.sv
hbus_ctrl_fsm.sv
hbus_ca_shifter.sv
hbus_data_path.sv
hbus_top.sv
tb_hbus_model.sv
tb_hbus.sv

//--- Makefile
TOP := tb_hbus

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): flist.f $(wildcard *.sv) $(wildcard *.svh)
	verilator --binary --timing --assert -f flist.f --top-module $(TOP)

lint:
	verilator --lint-only -Wall +incdir+. hbus_cmd_pkg.sv hbus_bus_pkg.sv \
	  hbus_seq_if.sv hbus_ctrl_fsm.sv hbus_ca_shifter.sv hbus_data_path.sv \
	  hbus_top.sv --top-module hbus_top

clean:
	rm -rf obj_dir
